/* verilog/fetch_pkg.sv */
package fetch_pkg;

  localparam int addr_w         = 32;
  localparam int inst_w         = 32;
  localparam int line_w         = 128;
  localparam int words_per_line = 4;
  localparam int fb_depth       = 4;  // also the number of memory credits
  localparam int fb_ptr_w       = 2;
  localparam int dec_credits    = 2;

  localparam int slot_w     = $clog2(words_per_line);
  localparam int inst_off_w = $clog2(inst_w / 8);  // byte offset inside a word
  localparam int line_off_w = $clog2(line_w / 8);  // byte offset inside a line
  localparam int fb_cnt_w   = fb_ptr_w + 1;        // holds 0..fb_depth
  localparam int dec_cnt_w  = $clog2(dec_credits + 1);

  typedef struct packed {
    logic [addr_w-1:0] line_addr;
    logic              epoch;
  } mem_req_t;

  typedef struct packed {
    logic [line_w-1:0] data;
    logic              epoch;
  } mem_rsp_t;

  typedef struct packed {
    logic [addr_w-1:0] pc;
    logic [inst_w-1:0] inst;
  } fetch_inst_t;

  typedef enum logic {
    slot_seq  = 1'b0,  // next line starts at slot 0
    slot_skip = 1'b1   // next line starts at the redirect slot
  } slot_mode_e;

endpackage

/* verilog/fetch_line_req.sv */
`timescale 1ns/100ps

module fetch_line_req import fetch_pkg::*; (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              redirect,
  input  logic [addr_w-1:0] redirect_pc,
  input  logic              mem_credit,
  input  logic              mem_rsp_valid,
  output logic              mem_req_valid,
  output mem_req_t          mem_req,
  output logic              cur_epoch
);

  logic [addr_w-1:0]   next_addr;
  logic [fb_cnt_w-1:0] credits;
  logic [fb_cnt_w-1:0] inflight;
  logic [fb_cnt_w-1:0] stale;     // old-epoch responses still to come back
  logic                epoch;

  logic [fb_cnt_w-1:0] inflight_now;
  logic [fb_cnt_w-1:0] credits_base;
  logic [fb_cnt_w-1:0] stale_base;
  logic [addr_w-1:0]   addr_base;
  logic                epoch_base;
  logic                issue;

  // with a one-bit epoch only one old stream may be in flight at a time,
  // so new requests wait until the stale ones have drained
  always_comb begin
    inflight_now = inflight + fb_cnt_w'(mem_req_valid) - fb_cnt_w'(mem_rsp_valid);
    if (redirect) begin
      credits_base = fb_cnt_w'(fb_depth) - inflight_now;
      stale_base   = inflight_now;  // everything in flight is now stale
      addr_base    = {redirect_pc[addr_w-1:line_off_w], {line_off_w{1'b0}}};
      epoch_base   = (stale == '0) ? ~epoch : epoch;
    end else begin
      credits_base = credits + fb_cnt_w'(mem_credit);
      stale_base   = stale - fb_cnt_w'(mem_rsp_valid && (stale != '0));
      addr_base    = next_addr;
      epoch_base   = epoch;
    end
    issue = (credits_base != '0) && (stale_base == '0);
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      mem_req_valid <= 1'b0;
      credits       <= fb_cnt_w'(fb_depth);
      inflight      <= '0;
      stale         <= '0;
      epoch         <= 1'b0;
      next_addr     <= '0;  // fetch starts at pc 0
    end else begin
      mem_req_valid <= issue;
      inflight      <= inflight_now;
      stale         <= stale_base;
      epoch         <= epoch_base;
      if (issue) begin
        credits   <= credits_base - 1'b1;
        next_addr <= addr_base + addr_w'(line_w / 8);
      end else begin
        credits   <= credits_base;
        next_addr <= addr_base;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (issue) begin
      mem_req <= '{line_addr: addr_base, epoch: epoch_base};
    end
  end

  assign cur_epoch = epoch;

  // free credits plus outstanding requests never exceed the buffer slots
  a_credit_bound: assert property (@(posedge clk) disable iff (!rst_n)
    (int'(credits) + int'(inflight)) <= fb_depth);

endmodule

/* verilog/fetch_buffer.sv */
`timescale 1ns/100ps

module fetch_buffer import fetch_pkg::*; (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              redirect,
  input  logic              cur_epoch,
  input  logic              mem_rsp_valid,
  input  mem_rsp_t          mem_rsp,
  input  logic              line_pop,
  output logic              line_valid,
  output logic [line_w-1:0] line_data,
  output logic              mem_credit
);

  logic [line_w-1:0]   lines [fb_depth];
  logic [fb_ptr_w:0]   wr_ptr;  // msb is the wrap bit
  logic [fb_ptr_w:0]   rd_ptr;
  logic                full;
  logic                empty;
  logic                wr_en;
  logic                drop;
  logic [fb_cnt_w-1:0] pend;
  logic [fb_cnt_w-1:0] pend_sum;

  assign full  = (rd_ptr == {~wr_ptr[fb_ptr_w], wr_ptr[fb_ptr_w-1:0]});
  assign empty = (rd_ptr == wr_ptr);

  // a response arriving with the redirect is covered by the credit reload
  assign wr_en = mem_rsp_valid && !redirect && (mem_rsp.epoch == cur_epoch);
  assign drop  = mem_rsp_valid && !redirect && (mem_rsp.epoch != cur_epoch);

  assign pend_sum = pend + fb_cnt_w'(line_pop) + fb_cnt_w'(drop);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else if (redirect) begin
      wr_ptr <= '0;  // flush
      rd_ptr <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (line_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  // one credit per cycle, extra ones wait in pend
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pend       <= '0;
      mem_credit <= 1'b0;
    end else if (redirect) begin
      pend       <= '0;
      mem_credit <= 1'b0;
    end else begin
      mem_credit <= (pend_sum != '0);
      pend       <= pend_sum - fb_cnt_w'(pend_sum != '0);
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      lines[wr_ptr[fb_ptr_w-1:0]] <= mem_rsp.data;
    end
  end

  assign line_valid = !empty;
  assign line_data  = lines[rd_ptr[fb_ptr_w-1:0]];

  // the memory credits must keep responses from overrunning the store
  a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
    wr_en |-> !full);

  a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
    line_pop |-> !empty);

endmodule

/* verilog/inst_align.sv */
`timescale 1ns/100ps

module inst_align import fetch_pkg::*; (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              redirect,
  input  logic [addr_w-1:0] redirect_pc,
  input  logic              line_valid,
  input  logic [line_w-1:0] line_data,
  input  logic              dec_credit,
  output logic              line_pop,
  output logic              inst_valid,
  output fetch_inst_t       inst_out
);

  logic [line_w-1:0]    line_q;
  logic                 have_line;
  logic [slot_w-1:0]    slot;
  logic [addr_w-1:0]    pc_q;
  slot_mode_e           mode;
  logic [dec_cnt_w-1:0] credits;
  logic                 last_slot;

  assign last_slot = (slot == slot_w'(words_per_line - 1));

  // nothing leaves in the redirect cycle
  assign inst_valid = have_line && (credits != '0) && !redirect;
  assign line_pop   = line_valid && !redirect && (!have_line || (inst_valid && last_slot));

  assign inst_out.pc   = pc_q;
  assign inst_out.inst = line_q[slot*inst_w +: inst_w];  // slot 0 in the low word

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      have_line <= 1'b0;
      slot      <= '0;
      pc_q      <= '0;
      mode      <= slot_seq;
    end else if (redirect) begin
      have_line <= 1'b0;  // drop the old-stream line
      slot      <= redirect_pc[inst_off_w +: slot_w];
      pc_q      <= {redirect_pc[addr_w-1:inst_off_w], {inst_off_w{1'b0}}};
      mode      <= slot_skip;
    end else begin
      if (inst_valid) begin
        pc_q <= pc_q + addr_w'(inst_w / 8);
        slot <= slot + 1'b1;
        if (last_slot) begin
          have_line <= 1'b0;
        end
      end
      if (line_pop) begin
        have_line <= 1'b1;
        mode      <= slot_seq;
        if (mode == slot_seq) begin
          slot <= '0;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (line_pop) begin
      line_q <= line_data;
    end
  end

  // decode credits
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      credits <= dec_cnt_w'(dec_credits);
    end else begin
      credits <= credits - dec_cnt_w'(inst_valid) + dec_cnt_w'(dec_credit);
    end
  end

  // decode never returns more credits than it took
  a_dec_credit: assert property (@(posedge clk) disable iff (!rst_n)
    int'(credits) <= dec_credits);

endmodule

/* verilog/fetch_top.sv */
`timescale 1ns/100ps

module fetch_top import fetch_pkg::*; (
  input  logic              clk,
  input  logic              rst_n,
  output logic              mem_req_valid,
  output mem_req_t          mem_req,
  input  logic              mem_rsp_valid,
  input  mem_rsp_t          mem_rsp,
  output logic              inst_valid,
  output fetch_inst_t       inst_out,
  input  logic              dec_credit,
  input  logic              redirect,
  input  logic [addr_w-1:0] redirect_pc
);

  logic              mem_credit;
  logic              cur_epoch;
  logic              line_valid;
  logic [line_w-1:0] line_data;
  logic              line_pop;

  fetch_line_req line_req_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .redirect      (redirect),
    .redirect_pc   (redirect_pc),
    .mem_credit    (mem_credit),
    .mem_rsp_valid (mem_rsp_valid),
    .mem_req_valid (mem_req_valid),
    .mem_req       (mem_req),
    .cur_epoch     (cur_epoch)
  );

  fetch_buffer buffer_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .redirect      (redirect),
    .cur_epoch     (cur_epoch),
    .mem_rsp_valid (mem_rsp_valid),
    .mem_rsp       (mem_rsp),
    .line_pop      (line_pop),
    .line_valid    (line_valid),
    .line_data     (line_data),
    .mem_credit    (mem_credit)
  );

  inst_align align_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .line_valid  (line_valid),
    .line_data   (line_data),
    .dec_credit  (dec_credit),
    .line_pop    (line_pop),
    .inst_valid  (inst_valid),
    .inst_out    (inst_out)
  );

endmodule

/* testbench/mem_model.sv */
`timescale 1ns/100ps

module mem_model import fetch_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     mem_req_valid,
  input  mem_req_t mem_req,
  input  int       lat_lo,
  input  int       lat_hi,
  output logic     mem_rsp_valid,
  output mem_rsp_t mem_rsp,
  output int       pending
);

  mem_req_t req_q[$];
  int       due_q[$];
  int       cyc = 0;
  int       last_due = 0;

  // word at pc p is (p ^ c0de0000) rotated left by 5, slot 0 in the low word
  function automatic logic [line_w-1:0] line_at(input logic [addr_w-1:0] base);
    logic [line_w-1:0] line;
    logic [inst_w-1:0] word;
    for (int w = 0; w < words_per_line; w++) begin
      word = (base + addr_w'(4 * w)) ^ 32'hc0de0000;
      line[w*inst_w +: inst_w] = {word[26:0], word[31:27]};
    end
    return line;
  endfunction

  initial begin
    mem_rsp_valid = 1'b0;
    mem_rsp       = '0;
    pending       = 0;
  end

  always @(posedge clk) begin
    int lat;
    int due;
    cyc = cyc + 1;
    if (!rst_n) begin
      req_q.delete();
      due_q.delete();
      last_due = 0;
    end else if (mem_req_valid) begin
      lat = lat_lo + int'($urandom % (lat_hi - lat_lo + 1));
      due = cyc + lat;
      if (due <= last_due) begin
        due = last_due + 1;  // keep request order
      end
      last_due = due;
      req_q.push_back(mem_req);
      due_q.push_back(due);
    end
  end

  always @(negedge clk) begin
    mem_rsp_valid = 1'b0;
    if (rst_n && due_q.size() > 0 && due_q[0] <= cyc) begin
      mem_rsp_valid = 1'b1;
      mem_rsp.data  = line_at(req_q[0].line_addr);
      mem_rsp.epoch = req_q[0].epoch;  // echoed
      void'(req_q.pop_front());
      void'(due_q.pop_front());
    end
    pending = due_q.size();
  end

endmodule

/* testbench/fetch_tb.sv */
`timescale 1ns/100ps

module fetch_tb import fetch_pkg::*; ();

  logic              clk;
  logic              rst_n;
  logic              redirect;
  logic [addr_w-1:0] redirect_pc;
  logic              dec_credit;
  logic              mem_req_valid;
  mem_req_t          mem_req;
  logic              mem_rsp_valid;
  mem_rsp_t          mem_rsp;
  logic              inst_valid;
  fetch_inst_t       inst_out;
  int                lat_lo;
  int                lat_hi;
  int                mem_pending;

  int                errors = 0;
  int                checks = 0;
  int                inst_count = 0;
  int                tests_run = 0;
  int                tests_failed = 0;
  logic [addr_w-1:0] exp_pc;
  logic              hold;
  int                credit_pct;
  int                owed = 0;
  logic              give = 1'b0;

  fetch_top fetch_top_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .mem_req_valid (mem_req_valid),
    .mem_req       (mem_req),
    .mem_rsp_valid (mem_rsp_valid),
    .mem_rsp       (mem_rsp),
    .inst_valid    (inst_valid),
    .inst_out      (inst_out),
    .dec_credit    (dec_credit),
    .redirect      (redirect),
    .redirect_pc   (redirect_pc)
  );

  mem_model mem_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .mem_req_valid (mem_req_valid),
    .mem_req       (mem_req),
    .lat_lo        (lat_lo),
    .lat_hi        (lat_hi),
    .mem_rsp_valid (mem_rsp_valid),
    .mem_rsp       (mem_rsp),
    .pending       (mem_pending)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic logic [inst_w-1:0] expected_inst(input logic [addr_w-1:0] pc);
    logic [inst_w-1:0] x;
    x = pc ^ 32'hc0de0000;
    return (x << 5) | (x >> 27);
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at %0d ns: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  // decides at the rising edge, drives at the falling edge
  always @(posedge clk) begin
    if (inst_valid) begin
      owed++;
    end
    give = 1'b0;
    if (!hold && owed > 0 && int'($urandom % 100) < credit_pct) begin
      give = 1'b1;
      owed--;
    end
  end

  always @(negedge clk) begin
    dec_credit = give;
  end

  always @(posedge clk) begin
    if (!rst_n) begin
      exp_pc = '0;
    end else if (redirect) begin
      exp_pc = redirect_pc;  // new stream starts here
    end else if (inst_valid) begin
      check_value("inst_out.pc", inst_out.pc, exp_pc);
      check_value("inst_out.inst", inst_out.inst, expected_inst(exp_pc));
      exp_pc = exp_pc + 4;
      inst_count++;
    end
  end

  task automatic wait_insts(input int n, input int limit, input string what);
    int target;
    int cycles;
    target = inst_count + n;
    cycles = 0;
    while (inst_count < target && cycles < limit) begin
      @(negedge clk);
      cycles++;
    end
    if (inst_count < target) begin
      errors++;
      $display("timeout at %0d ns: %s, %0d of %0d instructions arrived in %0d cycles",
               $time, what, n - (target - inst_count), n, limit);
    end
  endtask

  // called at a falling edge, returns at the next one
  task automatic pulse_redirect(input logic [addr_w-1:0] pc);
    redirect    = 1'b1;
    redirect_pc = pc;
    @(negedge clk);
    redirect    = 1'b0;
  endtask

  task automatic finish_test(input string name, input int err_before);
    tests_run++;
    if (errors == err_before) begin
      $display("test %0d %s: ok", tests_run, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: FAILED, %0d errors", tests_run, name, errors - err_before);
    end
  endtask

  initial begin
    int err0;
    int n0;
    int cycles;
    int r;
    void'($urandom(32'h35ef));
    rst_n       = 1'b0;
    redirect    = 1'b0;
    redirect_pc = '0;
    dec_credit  = 1'b0;
    hold        = 1'b0;
    credit_pct  = 100;
    lat_lo      = 1;
    lat_hi      = 6;
    repeat (5) @(negedge clk);
    rst_n = 1'b1;

    err0 = errors;
    wait_insts(40, 400, "sequential fetch from pc 0");
    finish_test("sequential fetch", err0);

    err0 = errors;
    hold = 1'b1;
    n0   = inst_count;
    repeat (100) @(negedge clk);
    if (inst_count - n0 > dec_credits) begin
      errors++;
      $display("%0d instructions passed while decode held its credits, limit is %0d",
               inst_count - n0, dec_credits);
    end
    hold = 1'b0;
    wait_insts(40, 400, "fetch after decode released credits");
    finish_test("decode back-pressure", err0);

    err0 = errors;
    pulse_redirect(32'h0000_0208);  // slot 2
    wait_insts(20, 300, "fetch after mid-line redirect");
    finish_test("mid-line redirect", err0);

    err0   = errors;
    lat_lo = 6;
    lat_hi = 6;
    wait_insts(8, 200, "fetch with long latency");
    cycles = 0;
    @(posedge clk);
    while (mem_pending < 2 && cycles < 100) begin
      @(posedge clk);
      cycles++;
    end
    if (mem_pending < 2) begin
      errors++;
      $display("no two memory responses were ever in flight before the redirect");
    end
    @(negedge clk);
    pulse_redirect(32'h0000_1004);
    wait_insts(40, 200, "fetch after redirect with responses in flight");
    lat_lo = 1;
    lat_hi = 6;
    finish_test("redirect in flight", err0);

    err0 = errors;
    for (int c = 0; c < 500; c++) begin
      @(negedge clk);
      if (c % 50 == 0) begin
        credit_pct = 20 + int'($urandom % 81);
      end
      r = int'($urandom % 100);
      if (r < 4 || (redirect && r < 30)) begin  // second term gives back-to-back pulses
        redirect    = 1'b1;
        redirect_pc = addr_w'(($urandom % 1024) * 4);
      end else begin
        redirect = 1'b0;
      end
    end
    @(negedge clk);
    redirect   = 1'b0;
    credit_pct = 100;
    wait_insts(20, 300, "fetch after random redirects");
    finish_test("random redirects", err0);

    $display("tests run %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

/* vlog.f */
verilog/fetch_pkg.sv
verilog/fetch_line_req.sv
verilog/fetch_buffer.sv
verilog/inst_align.sv
verilog/fetch_top.sv
testbench/mem_model.sv
testbench/fetch_tb.sv

/* Makefile */
SRCS := $(shell grep -v '^+' vlog.f)

.PHONY: run clean

run: obj_dir/Vfetch_tb
	./obj_dir/Vfetch_tb > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "STATUS: FAIL" sim.log; then \
	  echo "simulation reported a failure"; exit 1; \
	fi
	@grep -q "STATUS: PASS" sim.log || (echo "simulation ended without a result"; exit 1)

# rebuilt only when the file list or a source changes
obj_dir/V%: vlog.f $(SRCS)
	verilator --binary --timing --assert -j 0 --top-module $* -f vlog.f \
	  -Mdir obj_dir -o V$*

clean:
	rm -rf obj_dir sim.log
